/* verilog/csr_pkg.sv */
package csr_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Protection register geometry
    ///////////////////////////////////////////////////////////////////////

    // Every protection CSR is one machine word
    localparam int CSR_WIDTH = 32;

    // Custom machine-mode space, enable first, then instruction and data
    typedef enum logic [11:0] {
        MVMCTL = 12'h7C0,   // enable, bit 0 only
        MVMIO  = 12'h7C1,   // instruction offset
        MVMIS  = 12'h7C2,   // instruction size
        MVMIM  = 12'h7C3,   // instruction mask
        MVMDO  = 12'h7C4,   // data offset
        MVMDS  = 12'h7C5,   // data size
        MVMDM  = 12'h7C6    // data mask
    } csr_addr_e;

    ///////////////////////////////////////////////////////////////////////
    // Privilege levels
    ///////////////////////////////////////////////////////////////////////

    // Standard RISC-V encoding, 2'b10 reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } privilege_e;

endpackage

/* verilog/mem_pkg.sv */
package mem_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Memory side addressing
    ///////////////////////////////////////////////////////////////////////

    // Default byte address width of the core
    localparam int ADDR_WIDTH = 32;

    ///////////////////////////////////////////////////////////////////////
    // Translation channels
    ///////////////////////////////////////////////////////////////////////

    // One channel for fetch, one for load/store
    localparam int NUM_CHANNELS = 2;

    // Channel index of the instruction fetch path
    localparam int CH_INST = 0;

    // Channel index of the data access path
    localparam int CH_DATA = 1;

    // Arrays indexed by channel follow this order everywhere:
    // offset, size and mask registers, translated addresses
    // and fault flags

endpackage

/* verilog/xosvm_csr.sv */
`timescale 1ns/1ps

module xosvm_csr #(
    parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  csr_pkg::privilege_e           privilege_i,

    input  logic                          csr_write_enable_i,
    input  logic                          csr_read_enable_i,
    input  logic [11:0]                   csr_address_i,
    input  logic [csr_pkg::CSR_WIDTH-1:0] csr_data_i,
    output logic [csr_pkg::CSR_WIDTH-1:0] csr_data_o,

    output logic                          mmu_en_o,
    output logic [ADDR_WIDTH-1:0]         offset_o [mem_pkg::NUM_CHANNELS],
    output logic [ADDR_WIDTH-1:0]         size_o   [mem_pkg::NUM_CHANNELS],
    output logic [ADDR_WIDTH-1:0]         mask_o   [mem_pkg::NUM_CHANNELS]
);

    import csr_pkg::*;
    import mem_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Register storage
    //////////////////////////////////////////////////////////////////////

    // Protection enable, the only live bit of MVMCTL
    logic                  vm_enable_q;

    // Per channel translation window
    logic [ADDR_WIDTH-1:0] offset_q [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0] size_q   [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0] mask_q   [NUM_CHANNELS];

    // Write data cut down to address width
    logic [ADDR_WIDTH-1:0] wdata;

    assign wdata = ADDR_WIDTH'(csr_data_i);

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    // One-cycle strobe, new value seen after the edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vm_enable_q <= 1'b0;
            offset_q    <= '{default: '0};
            size_q      <= '{default: '0};
            mask_q      <= '{default: '0};
        end
        else if (csr_write_enable_i) begin
            case (csr_address_i)
                MVMCTL:  vm_enable_q       <= csr_data_i[0];
                MVMIO:   offset_q[CH_INST] <= wdata;
                MVMIS:   size_q[CH_INST]   <= wdata;
                MVMIM:   mask_q[CH_INST]   <= wdata;
                MVMDO:   offset_q[CH_DATA] <= wdata;
                MVMDS:   size_q[CH_DATA]   <= wdata;
                MVMDM:   mask_q[CH_DATA]   <= wdata;
                // Unknown address, write dropped
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Combinational, zero when idle or unknown
    always_comb begin
        csr_data_o = '0;
        if (csr_read_enable_i) begin
            case (csr_address_i)
                MVMCTL:  csr_data_o = CSR_WIDTH'(vm_enable_q);
                MVMIO:   csr_data_o = CSR_WIDTH'(offset_q[CH_INST]);
                MVMIS:   csr_data_o = CSR_WIDTH'(size_q[CH_INST]);
                MVMIM:   csr_data_o = CSR_WIDTH'(mask_q[CH_INST]);
                MVMDO:   csr_data_o = CSR_WIDTH'(offset_q[CH_DATA]);
                MVMDS:   csr_data_o = CSR_WIDTH'(size_q[CH_DATA]);
                MVMDM:   csr_data_o = CSR_WIDTH'(mask_q[CH_DATA]);
                default: csr_data_o = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Protection enable and channel outputs
    //////////////////////////////////////////////////////////////////////

    // Machine mode always sees physical addresses
    assign mmu_en_o = vm_enable_q && (privilege_i != PRIV_MACHINE);

    // Window registers straight to the translation units
    assign offset_o = offset_q;
    assign size_o   = size_q;
    assign mask_o   = mask_q;

endmodule

/* verilog/mmu.sv */
`timescale 1ns/1ps

module mmu #(
    parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH
) (
    input  logic                  en_i,
    input  logic [ADDR_WIDTH-1:0] mask_i,
    input  logic [ADDR_WIDTH-1:0] offset_i,
    input  logic [ADDR_WIDTH-1:0] size_i,
    input  logic [ADDR_WIDTH-1:0] address_i,
    output logic [ADDR_WIDTH-1:0] address_o,
    output logic                  exception_o
);

    // Virtual address placed inside the window
    logic [ADDR_WIDTH-1:0] translated;

    // Out of bounds test on the untranslated address
    logic                  out_of_bounds;

    //////////////////////////////////////////////////////////////////////
    // Translation
    //////////////////////////////////////////////////////////////////////

    // Mask first, then relocate by the offset
    assign translated = (address_i & mask_i) + offset_i;

    // Size is an exclusive upper limit
    assign out_of_bounds = (address_i >= size_i);

    //////////////////////////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////////////////////////

    // Pass through when protection is off
    assign address_o   = en_i ? translated : address_i;

    // No fault possible without protection
    assign exception_o = en_i && out_of_bounds;

endmodule

/* verilog/mem_port.sv */
`timescale 1ns/1ps

module mem_port #(
    parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            stall_i,

    // Translated addresses and faults, one per channel
    input  logic [ADDR_WIDTH-1:0]           address_i [mem_pkg::NUM_CHANNELS],
    input  logic [mem_pkg::NUM_CHANNELS-1:0] fault_i,

    // Access strobes from the core
    input  logic                            mem_read_enable_i,
    input  logic [3:0]                      mem_write_enable_i,

    // Memory side
    output logic [ADDR_WIDTH-1:0]           instruction_address_o,
    output logic                            inst_fault_o,
    output logic [ADDR_WIDTH-1:0]           mem_address_o,
    output logic [3:0]                      mem_write_enable_o,
    output logic                            mem_operation_enable_o,
    output logic                            data_fault_o
);

    import mem_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Access gating
    //////////////////////////////////////////////////////////////////////

    // Any load or byte lane write counts as an access
    logic access_req;

    // Access that survives the bounds check
    logic op_enable;

    assign access_req = mem_read_enable_i || (mem_write_enable_i != 4'b0000);

    // A faulting data address never reaches memory
    assign op_enable  = access_req && !fault_i[CH_DATA];

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    // Single register stage, frozen while stalled
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instruction_address_o  <= '0;
            inst_fault_o           <= 1'b0;
            mem_address_o          <= '0;
            mem_write_enable_o     <= 4'b0000;
            mem_operation_enable_o <= 1'b0;
            data_fault_o           <= 1'b0;
        end
        else if (!stall_i) begin
            // Fetch channel
            instruction_address_o  <= address_i[CH_INST];
            inst_fault_o           <= fault_i[CH_INST];

            // Data channel
            mem_address_o          <= address_i[CH_DATA];
            mem_write_enable_o     <= mem_write_enable_i;
            mem_operation_enable_o <= op_enable;
            data_fault_o           <= fault_i[CH_DATA];
        end
    end

endmodule

/* verilog/xosvm_top.sv */
`timescale 1ns/1ps

module xosvm_top #(
    parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          stall_i,
    input  csr_pkg::privilege_e           privilege_i,

    // CSR access from the core
    input  logic                          csr_write_enable_i,
    input  logic                          csr_read_enable_i,
    input  logic [11:0]                   csr_address_i,
    input  logic [csr_pkg::CSR_WIDTH-1:0] csr_data_i,
    output logic [csr_pkg::CSR_WIDTH-1:0] csr_data_o,

    // Untranslated addresses and access strobes
    input  logic [ADDR_WIDTH-1:0]         instruction_address_i,
    input  logic [ADDR_WIDTH-1:0]         mem_address_i,
    input  logic                          mem_read_enable_i,
    input  logic [3:0]                    mem_write_enable_i,

    // Registered memory side
    output logic [ADDR_WIDTH-1:0]         instruction_address_o,
    output logic                          inst_fault_o,
    output logic [ADDR_WIDTH-1:0]         mem_address_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic                          mem_operation_enable_o,
    output logic                          data_fault_o
);

    import mem_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    logic                    mmu_en;
    logic [ADDR_WIDTH-1:0]   offset    [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0]   size      [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0]   mask      [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0]   virt_addr [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0]   phys_addr [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] fault;

    // Channel order, fetch then data
    assign virt_addr[CH_INST] = instruction_address_i;
    assign virt_addr[CH_DATA] = mem_address_i;

    //////////////////////////////////////////////////////////////////////
    // Protection registers
    //////////////////////////////////////////////////////////////////////

    xosvm_csr #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) xosvm_csr_inst (
        .clk                (clk               ),
        .rst_n_i            (rst_n_i           ),
        .privilege_i        (privilege_i       ),
        .csr_write_enable_i (csr_write_enable_i),
        .csr_read_enable_i  (csr_read_enable_i ),
        .csr_address_i      (csr_address_i     ),
        .csr_data_i         (csr_data_i        ),
        .csr_data_o         (csr_data_o        ),
        .mmu_en_o           (mmu_en            ),
        .offset_o           (offset            ),
        .size_o             (size              ),
        .mask_o             (mask              )
    );

    //////////////////////////////////////////////////////////////////////
    // Translation, one unit per channel
    //////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : gen_mmu
        mmu #(
            .ADDR_WIDTH (ADDR_WIDTH)
        ) mmu_inst (
            .en_i        (mmu_en       ),
            .mask_i      (mask[ch]     ),
            .offset_i    (offset[ch]   ),
            .size_i      (size[ch]     ),
            .address_i   (virt_addr[ch]),
            .address_o   (phys_addr[ch]),
            .exception_o (fault[ch]    )
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Memory port
    //////////////////////////////////////////////////////////////////////

    mem_port #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) mem_port_inst (
        .clk                    (clk                   ),
        .rst_n_i                (rst_n_i               ),
        .stall_i                (stall_i               ),
        .address_i              (phys_addr             ),
        .fault_i                (fault                 ),
        .mem_read_enable_i      (mem_read_enable_i     ),
        .mem_write_enable_i     (mem_write_enable_i    ),
        .instruction_address_o  (instruction_address_o ),
        .inst_fault_o           (inst_fault_o          ),
        .mem_address_o          (mem_address_o         ),
        .mem_write_enable_o     (mem_write_enable_o    ),
        .mem_operation_enable_o (mem_operation_enable_o),
        .data_fault_o           (data_fault_o          )
    );

endmodule

/* tb/tb_xosvm_top.sv */
`timescale 1ns/1ps

module tb_xosvm_top;

    import csr_pkg::*;
    import mem_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 3;
    localparam int PASS_VECTORS  = 8;
    localparam int RAND_VECTORS  = 40;
    localparam int STALL_CYCLES  = 5;
    // Two cycles per CSR write, CSR read and access vector
    localparam int TEST_CYCLES   = RESET_CYCLES + 2 + 2 * 20 + 2 * 25
                                 + 2 * (2 * PASS_VECTORS + RAND_VECTORS + 8) + STALL_CYCLES + 4;
    localparam int MARGIN_CYCLES = 100;

    logic                  clk;
    logic                  rst_n;
    logic                  stall;
    privilege_e            privilege;
    logic                  csr_we;
    logic                  csr_re;
    logic [11:0]           csr_addr;
    logic [CSR_WIDTH-1:0]  csr_wdata;
    logic [CSR_WIDTH-1:0]  csr_rdata;
    logic [ADDR_WIDTH-1:0] inst_addr;
    logic [ADDR_WIDTH-1:0] data_addr;
    logic                  rd_en;
    logic [3:0]            wr_en;

    // Registered memory side of the DUT
    logic [ADDR_WIDTH-1:0] inst_addr_out;
    logic                  inst_fault;
    logic [ADDR_WIDTH-1:0] data_addr_out;
    logic [3:0]            wr_en_out;
    logic                  op_en;
    logic                  data_fault;

    // Reference copy of the protection registers
    logic                  model_en;
    logic [ADDR_WIDTH-1:0] model_off  [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0] model_size [NUM_CHANNELS];
    logic [ADDR_WIDTH-1:0] model_mask [NUM_CHANNELS];

    integer                seed;
    int                    value_errors;

    xosvm_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) xosvm_top_inst (
        .clk                    (clk          ),
        .rst_n_i                (rst_n        ),
        .stall_i                (stall        ),
        .privilege_i            (privilege    ),
        .csr_write_enable_i     (csr_we       ),
        .csr_read_enable_i      (csr_re       ),
        .csr_address_i          (csr_addr     ),
        .csr_data_i             (csr_wdata    ),
        .csr_data_o             (csr_rdata    ),
        .instruction_address_i  (inst_addr    ),
        .mem_address_i          (data_addr    ),
        .mem_read_enable_i      (rd_en        ),
        .mem_write_enable_i     (wr_en        ),
        .instruction_address_o  (inst_addr_out),
        .inst_fault_o           (inst_fault   ),
        .mem_address_o          (data_addr_out),
        .mem_write_enable_o     (wr_en_out    ),
        .mem_operation_enable_o (op_en        ),
        .data_fault_o           (data_fault   )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stops making progress
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout, tests still running after %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("Checks stopped, value errors: %0d, timeouts: 1", value_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Protection off when disabled or in machine mode
    function automatic logic [ADDR_WIDTH-1:0] translated_address(input int ch,
                                                                 input logic [ADDR_WIDTH-1:0] addr);
        if (model_en && privilege != PRIV_MACHINE)
            return (addr & model_mask[ch]) + model_off[ch];
        return addr;
    endfunction

    // Size is exclusive
    function automatic logic bounds_fault(input int ch, input logic [ADDR_WIDTH-1:0] addr);
        return model_en && (privilege != PRIV_MACHINE) && (addr >= model_size[ch]);
    endfunction

    function automatic logic [CSR_WIDTH-1:0] readback_value(input logic [11:0] addr);
        case (addr)
            MVMCTL:  return CSR_WIDTH'(model_en);
            MVMIO:   return model_off[CH_INST];
            MVMIS:   return model_size[CH_INST];
            MVMIM:   return model_mask[CH_INST];
            MVMDO:   return model_off[CH_DATA];
            MVMDS:   return model_size[CH_DATA];
            MVMDM:   return model_mask[CH_DATA];
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_idle_outputs();
        compare_value("instruction_address_o", '0, inst_addr_out);
        compare_value("inst_fault_o", '0, inst_fault);
        compare_value("mem_address_o", '0, data_addr_out);
        compare_value("mem_write_enable_o", '0, wr_en_out);
        compare_value("mem_operation_enable_o", '0, op_en);
        compare_value("data_fault_o", '0, data_fault);
    endtask

    // One-cycle strobe with the model updated after the edge
    task automatic write_csr(input logic [11:0] addr, input logic [CSR_WIDTH-1:0] data);
        @(posedge clk);
        csr_we    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_we <= 1'b0;
        case (addr)
            MVMCTL:  model_en            = data[0];
            MVMIO:   model_off[CH_INST]  = data;
            MVMIS:   model_size[CH_INST] = data;
            MVMIM:   model_mask[CH_INST] = data;
            MVMDO:   model_off[CH_DATA]  = data;
            MVMDS:   model_size[CH_DATA] = data;
            MVMDM:   model_mask[CH_DATA] = data;
            default: ;
        endcase
    endtask

    task automatic read_csr(input logic [11:0] addr);
        @(posedge clk);
        csr_re   <= 1'b1;
        csr_addr <= addr;
        @(negedge clk);
        compare_value("csr_data_o", readback_value(addr), csr_rdata);
        @(posedge clk);
        csr_re <= 1'b0;
    endtask

    task automatic set_privilege(input privilege_e level);
        @(posedge clk);
        privilege <= level;
    endtask

    // Applied on one edge and captured on the next, then checked mid cycle
    task automatic access_check(input logic [ADDR_WIDTH-1:0] inst,
                                input logic [ADDR_WIDTH-1:0] data,
                                input logic rd, input logic [3:0] wr);
        logic exp_dfault;
        @(posedge clk);
        inst_addr <= inst;
        data_addr <= data;
        rd_en     <= rd;
        wr_en     <= wr;
        @(posedge clk);
        @(negedge clk);
        exp_dfault = bounds_fault(CH_DATA, data);
        compare_value("instruction_address_o", translated_address(CH_INST, inst), inst_addr_out);
        compare_value("inst_fault_o", bounds_fault(CH_INST, inst), inst_fault);
        compare_value("mem_address_o", translated_address(CH_DATA, data), data_addr_out);
        compare_value("data_fault_o", exp_dfault, data_fault);
        compare_value("mem_write_enable_o", wr, wr_en_out);
        compare_value("mem_operation_enable_o", (rd || wr != 4'b0000) && !exp_dfault, op_en);
    endtask

    // Outputs frozen while inputs keep moving
    task automatic hold_during_stall(input int cycles);
        logic [ADDR_WIDTH-1:0] held_inst;
        logic [ADDR_WIDTH-1:0] held_data;
        logic [3:0]            held_wr;
        logic [2:0]            held_flags;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        held_inst  = inst_addr_out;
        held_data  = data_addr_out;
        held_wr    = wr_en_out;
        held_flags = {inst_fault, data_fault, op_en};
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            inst_addr <= $random(seed);
            data_addr <= $random(seed);
            rd_en     <= $random(seed);
            wr_en     <= $random(seed);
            @(negedge clk);
            compare_value("instruction_address_o", held_inst, inst_addr_out);
            compare_value("mem_address_o", held_data, data_addr_out);
            compare_value("mem_write_enable_o", held_wr, wr_en_out);
            compare_value("inst_fault_o", held_flags[2], inst_fault);
            compare_value("data_fault_o", held_flags[1], data_fault);
            compare_value("mem_operation_enable_o", held_flags[0], op_en);
        end
        @(posedge clk);
        stall <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed         = 32'hb6854634;
        value_errors = 0;
        rst_n        = 1'b0;
        stall        = 1'b0;
        privilege    = PRIV_USER;
        csr_we       = 1'b0;
        csr_re       = 1'b0;
        csr_addr     = '0;
        csr_wdata    = '0;
        inst_addr    = '0;
        data_addr    = '0;
        rd_en        = 1'b0;
        wr_en        = 4'b0000;
        model_en     = 1'b0;
        model_off    = '{default: '0};
        model_size   = '{default: '0};
        model_mask   = '{default: '0};

        // Reset state during reset and after the first edge out of it
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_idle_outputs();

        // Register readback with only bit 0 kept in the enable
        for (int a = 1; a < 7; a++)
            write_csr(12'h7C0 + a, $random(seed));
        write_csr(MVMCTL, 32'hFFFF_FFFF);
        for (int a = 0; a < 9; a++)
            read_csr(12'h7C0 + a);
        // Unknown addresses drop writes and read as zero
        write_csr(12'h7C7, 32'hDEAD_BEEF);
        write_csr(12'h000, 32'h1234_5678);
        read_csr(12'h000);
        for (int a = 0; a < 8; a++)
            read_csr(12'h7C0 + a);
        write_csr(MVMCTL, 32'hFFFF_FFFE);
        read_csr(MVMCTL);

        // Pass through when disabled and then in machine mode
        for (int i = 0; i < PASS_VECTORS; i++)
            access_check($random(seed), $random(seed), $random(seed), $random(seed));
        write_csr(MVMCTL, 32'h1);
        set_privilege(PRIV_MACHINE);
        for (int i = 0; i < PASS_VECTORS; i++)
            access_check($random(seed), $random(seed), $random(seed), $random(seed));

        // Windows that cut the random ranges roughly in half
        write_csr(MVMIO, 32'h8000_0000);
        write_csr(MVMIS, 32'h0001_0000);
        write_csr(MVMIM, 32'h0000_FFFF);
        write_csr(MVMDO, 32'h4000_0000);
        write_csr(MVMDS, 32'h0000_1000);
        write_csr(MVMDM, 32'h0000_0FFC);
        set_privilege(PRIV_USER);
        for (int i = 0; i < RAND_VECTORS; i++) begin
            if (i == RAND_VECTORS / 2)
                set_privilege(PRIV_SUPERVISOR);
            access_check($random(seed) & 32'h0001_FFFF, $random(seed) & 32'h0000_1FFF,
                         $random(seed), $random(seed));
        end

        // Stall hold followed by a resumed access
        hold_during_stall(STALL_CYCLES);
        access_check(32'h0000_0100, 32'h0000_0204, 1'b1, 4'b0000);

        $display("Checks done, value errors: %0d, timeouts: 0", value_errors);
        if (value_errors == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
verilog/csr_pkg.sv
verilog/mem_pkg.sv
verilog/xosvm_csr.sv
verilog/mmu.sv
verilog/mem_port.sv
verilog/xosvm_top.sv
tb/tb_xosvm_top.sv

/* Bender.yml */
package:
  name: xosvm

sources:
  - verilog/csr_pkg.sv
  - verilog/mem_pkg.sv
  - verilog/xosvm_csr.sv
  - verilog/mmu.sv
  - verilog/mem_port.sv
  - verilog/xosvm_top.sv
  - target: test
    files:
      - tb/tb_xosvm_top.sv
